// ==== verilog/riscv_pkg.sv ====
package riscv_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  localparam int XLEN       = 64;  // Data width
  localparam int REG_ADDR_W = 5;   // Register address width
  localparam int IMMSRC_W   = 3;   // Immediate-format select width

  // Immediate-format codes with 5 to 7 reserved for a zero immediate
  localparam logic [IMMSRC_W-1:0] IMM_I = 3'd0;
  localparam logic [IMMSRC_W-1:0] IMM_S = 3'd1;
  localparam logic [IMMSRC_W-1:0] IMM_B = 3'd2;
  localparam logic [IMMSRC_W-1:0] IMM_U = 3'd3;
  localparam logic [IMMSRC_W-1:0] IMM_J = 3'd4;

  localparam logic [31:0] NOP_INST = 32'h0000_0013;  // addi x0, x0, 0

  //////////////////////////////
  // Instruction formats
  //////////////////////////////

  typedef union packed {
    struct packed {
      logic [6:0]            funct7;
      logic [REG_ADDR_W-1:0] rs2;
      logic [REG_ADDR_W-1:0] rs1;
      logic [2:0]            funct3;
      logic [REG_ADDR_W-1:0] rd;
      logic [6:0]            opcode;
    } r_type;
    struct packed {
      logic [11:0]           imm;
      logic [REG_ADDR_W-1:0] rs1;
      logic [2:0]            funct3;
      logic [REG_ADDR_W-1:0] rd;
      logic [6:0]            opcode;
    } i_type;
    struct packed {
      logic [6:0]            imm_hi;   // imm[11:5]
      logic [REG_ADDR_W-1:0] rs2;
      logic [REG_ADDR_W-1:0] rs1;
      logic [2:0]            funct3;
      logic [4:0]            imm_lo;   // imm[4:0]
      logic [6:0]            opcode;
    } s_type;
    struct packed {
      logic                  imm12;
      logic [5:0]            imm10_5;
      logic [REG_ADDR_W-1:0] rs2;
      logic [REG_ADDR_W-1:0] rs1;
      logic [2:0]            funct3;
      logic [3:0]            imm4_1;
      logic                  imm11;
      logic [6:0]            opcode;
    } b_type;
    struct packed {
      logic [31:12]          imm;
      logic [REG_ADDR_W-1:0] rd;
      logic [6:0]            opcode;
    } u_type;
    struct packed {
      logic                  imm20;
      logic [9:0]            imm10_1;
      logic                  imm11;
      logic [7:0]            imm19_12;
      logic [REG_ADDR_W-1:0] rd;
      logic [6:0]            opcode;
    } j_type;
  } riscv_inst_u;

endpackage

// ==== verilog/riscv_rf_if.sv ====
`timescale 1ns/1ps

interface riscv_rf_if #(
  parameter int XLEN       = riscv_pkg::XLEN,
  parameter int REG_ADDR_W = riscv_pkg::REG_ADDR_W
);

  logic [REG_ADDR_W-1:0] rs1_addr;
  logic [REG_ADDR_W-1:0] rs2_addr;
  logic                  wr_en;
  logic [REG_ADDR_W-1:0] wr_addr;
  logic [XLEN-1:0]       wr_data;
  logic [XLEN-1:0]       rs1_data;   // Combinational read
  logic [XLEN-1:0]       rs2_data;   // Combinational read

  modport dstage (
    output rs1_addr, rs2_addr, wr_en, wr_addr, wr_data,
    input  rs1_data, rs2_data
  );

  modport rf (
    input  rs1_addr, rs2_addr, wr_en, wr_addr, wr_data,
    output rs1_data, rs2_data
  );

endinterface

// ==== verilog/riscv_rf.sv ====
`timescale 1ns/1ps

module riscv_rf #(
  parameter int XLEN       = riscv_pkg::XLEN,
  parameter int REG_ADDR_W = riscv_pkg::REG_ADDR_W
) (
  input  logic   i_riscv_rf_clk,
  input  logic   i_rst_n,
  riscv_rf_if.rf rf_port
);

  localparam int NUM_REGS = 2**REG_ADDR_W;

  logic [XLEN-1:0] regs [1:NUM_REGS-1];  // x0 is not stored

  // Falling-edge write lands half a cycle before the next capture,
  // so a read in the same cycle already returns the new value
  always_ff @(negedge i_riscv_rf_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (rf_port.wr_en && (rf_port.wr_addr != '0)) begin
      regs[rf_port.wr_addr] <= rf_port.wr_data;  // Writes to x0 dropped
    end
  end

  always_comb begin
    rf_port.rs1_data = '0;  // x0 reads zero
    rf_port.rs2_data = '0;
    if (rf_port.rs1_addr != '0) begin
      rf_port.rs1_data = regs[rf_port.rs1_addr];
    end
    if (rf_port.rs2_addr != '0) begin
      rf_port.rs2_data = regs[rf_port.rs2_addr];
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  // Write-back request from outside must name a known register
  a_wr_addr_known : assert property (
    @(negedge i_riscv_rf_clk) disable iff (!i_rst_n)
    rf_port.wr_en |-> !$isunknown(rf_port.wr_addr)
  ) else $error("riscv_rf: write enabled with unknown address");

endmodule

// ==== verilog/riscv_extend.sv ====
`timescale 1ns/1ps

module riscv_extend #(
  parameter int XLEN = riscv_pkg::XLEN
) (
  input  logic [riscv_pkg::IMMSRC_W-1:0] i_riscv_extend_immsrc,
  input  riscv_pkg::riscv_inst_u         i_riscv_extend_inst,
  output logic [XLEN-1:0]                o_riscv_extend_simm
);

  logic            sign;   // Bit 31 in every format
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;

  assign sign = i_riscv_extend_inst.r_type.funct7[6];

  assign imm_i = {{(XLEN-12){sign}}, i_riscv_extend_inst.i_type.imm};

  assign imm_s = {{(XLEN-12){sign}},
                  i_riscv_extend_inst.s_type.imm_hi,
                  i_riscv_extend_inst.s_type.imm_lo};

  assign imm_b = {{(XLEN-12){sign}},          // imm12 is the sign
                  i_riscv_extend_inst.b_type.imm11,
                  i_riscv_extend_inst.b_type.imm10_5,
                  i_riscv_extend_inst.b_type.imm4_1,
                  1'b0};                      // Halfword aligned

  assign imm_u = {{(XLEN-32){sign}}, i_riscv_extend_inst.u_type.imm, 12'b0};

  assign imm_j = {{(XLEN-20){sign}},          // imm20 is the sign
                  i_riscv_extend_inst.j_type.imm19_12,
                  i_riscv_extend_inst.j_type.imm11,
                  i_riscv_extend_inst.j_type.imm10_1,
                  1'b0};                      // Halfword aligned

  always_comb begin
    case (i_riscv_extend_immsrc)
      riscv_pkg::IMM_I: o_riscv_extend_simm = imm_i;
      riscv_pkg::IMM_S: o_riscv_extend_simm = imm_s;
      riscv_pkg::IMM_B: o_riscv_extend_simm = imm_b;
      riscv_pkg::IMM_U: o_riscv_extend_simm = imm_u;
      riscv_pkg::IMM_J: o_riscv_extend_simm = imm_j;
      default:          o_riscv_extend_simm = '0;  // Reserved codes
    endcase
  end

endmodule

// ==== verilog/riscv_dstage.sv ====
`timescale 1ns/1ps

module riscv_dstage #(
  parameter int XLEN       = riscv_pkg::XLEN,
  parameter int REG_ADDR_W = riscv_pkg::REG_ADDR_W
) (
  input  logic                           i_riscv_dstage_clk,
  input  logic                           i_rst_n,
  input  logic [riscv_pkg::IMMSRC_W-1:0] i_riscv_dstage_immsrc,
  input  riscv_pkg::riscv_inst_u         i_riscv_dstage_inst,
  input  logic                           i_riscv_dstage_regw,
  input  logic [REG_ADDR_W-1:0]          i_riscv_dstage_rdaddr,
  input  logic [XLEN-1:0]                i_riscv_dstage_rddata,
  output logic [XLEN-1:0]                o_riscv_dstage_rs1data,
  output logic [XLEN-1:0]                o_riscv_dstage_rs2data,
  output logic [REG_ADDR_W-1:0]          o_riscv_dstage_rs1addr,
  output logic [REG_ADDR_W-1:0]          o_riscv_dstage_rs2addr,
  output logic [REG_ADDR_W-1:0]          o_riscv_dstage_rdaddr,
  output logic [XLEN-1:0]                o_riscv_dstage_simm,
  output logic [6:0]                     o_riscv_dstage_opcode,
  output logic [2:0]                     o_riscv_dstage_funct3,
  output logic [6:0]                     o_riscv_dstage_func7,
  output logic [XLEN-1:0]                o_riscv_dstage_immzeroextend
);

  riscv_rf_if #(.XLEN(XLEN), .REG_ADDR_W(REG_ADDR_W)) rf_bus ();

  //////////////////////////////
  // Field split
  //////////////////////////////

  assign o_riscv_dstage_opcode  = i_riscv_dstage_inst.r_type.opcode;
  assign o_riscv_dstage_funct3  = i_riscv_dstage_inst.r_type.funct3;
  assign o_riscv_dstage_func7   = i_riscv_dstage_inst.r_type.funct7;
  assign o_riscv_dstage_rs1addr = i_riscv_dstage_inst.r_type.rs1;
  assign o_riscv_dstage_rs2addr = i_riscv_dstage_inst.r_type.rs2;
  assign o_riscv_dstage_rdaddr  = i_riscv_dstage_inst.r_type.rd;

  // CSR immediate forms carry a 5-bit unsigned value in rs1
  assign o_riscv_dstage_immzeroextend = {{(XLEN-REG_ADDR_W){1'b0}},
                                         i_riscv_dstage_inst.r_type.rs1};

  //////////////////////////////
  // Register file access
  //////////////////////////////

  assign rf_bus.rs1_addr = i_riscv_dstage_inst.r_type.rs1;
  assign rf_bus.rs2_addr = i_riscv_dstage_inst.r_type.rs2;
  assign rf_bus.wr_en    = i_riscv_dstage_regw;     // Write-back request
  assign rf_bus.wr_addr  = i_riscv_dstage_rdaddr;
  assign rf_bus.wr_data  = i_riscv_dstage_rddata;

  assign o_riscv_dstage_rs1data = rf_bus.rs1_data;
  assign o_riscv_dstage_rs2data = rf_bus.rs2_data;

  riscv_rf #(.XLEN(XLEN), .REG_ADDR_W(REG_ADDR_W)) u_riscv_rf (
    .i_riscv_rf_clk (i_riscv_dstage_clk),
    .i_rst_n        (i_rst_n),
    .rf_port        (rf_bus.rf)
  );

  riscv_extend #(.XLEN(XLEN)) u_riscv_extend (
    .i_riscv_extend_immsrc (i_riscv_dstage_immsrc),
    .i_riscv_extend_inst   (i_riscv_dstage_inst),
    .o_riscv_extend_simm   (o_riscv_dstage_simm)
  );

  // The external select must pair with a real instruction; only the
  // bubble may carry a reserved code
  a_immsrc_legal : assert property (
    @(posedge i_riscv_dstage_clk) disable iff (!i_rst_n)
    (i_riscv_dstage_inst.r_type.opcode != riscv_pkg::NOP_INST[6:0])
      |-> (i_riscv_dstage_immsrc <= riscv_pkg::IMM_J)
  ) else $error("riscv_dstage: reserved immediate select on a live instruction");

endmodule

// ==== verilog/riscv_ppreg_fd.sv ====
`timescale 1ns/1ps

module riscv_ppreg_fd (
  input  logic                           i_riscv_ppreg_fd_clk,
  input  logic                           i_rst_n,
  input  logic                           i_riscv_ppreg_fd_stall,
  input  logic                           i_riscv_ppreg_fd_flush,
  input  riscv_pkg::riscv_inst_u         i_riscv_ppreg_fd_inst,
  input  logic [riscv_pkg::IMMSRC_W-1:0] i_riscv_ppreg_fd_immsrc,
  output riscv_pkg::riscv_inst_u         o_riscv_ppreg_fd_inst,
  output logic [riscv_pkg::IMMSRC_W-1:0] o_riscv_ppreg_fd_immsrc
);

  // Flush beats stall, stall beats load
  always_ff @(posedge i_riscv_ppreg_fd_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_riscv_ppreg_fd_inst   <= riscv_pkg::NOP_INST;
      o_riscv_ppreg_fd_immsrc <= riscv_pkg::IMM_I;
    end else if (i_riscv_ppreg_fd_flush) begin
      o_riscv_ppreg_fd_inst   <= riscv_pkg::NOP_INST;  // Bubble
      o_riscv_ppreg_fd_immsrc <= riscv_pkg::IMM_I;
    end else if (!i_riscv_ppreg_fd_stall) begin
      o_riscv_ppreg_fd_inst   <= i_riscv_ppreg_fd_inst;
      o_riscv_ppreg_fd_immsrc <= i_riscv_ppreg_fd_immsrc;
    end
  end

endmodule

// ==== verilog/riscv_ppreg_de.sv ====
`timescale 1ns/1ps

module riscv_ppreg_de #(
  parameter int XLEN       = riscv_pkg::XLEN,
  parameter int REG_ADDR_W = riscv_pkg::REG_ADDR_W
) (
  input  logic                  i_riscv_ppreg_de_clk,
  input  logic                  i_rst_n,
  input  logic                  i_riscv_ppreg_de_flush,
  input  logic [XLEN-1:0]       i_riscv_ppreg_de_rs1data,
  input  logic [XLEN-1:0]       i_riscv_ppreg_de_rs2data,
  input  logic [REG_ADDR_W-1:0] i_riscv_ppreg_de_rs1addr,
  input  logic [REG_ADDR_W-1:0] i_riscv_ppreg_de_rs2addr,
  input  logic [REG_ADDR_W-1:0] i_riscv_ppreg_de_rdaddr,
  input  logic [XLEN-1:0]       i_riscv_ppreg_de_simm,
  input  logic [6:0]            i_riscv_ppreg_de_opcode,
  input  logic [2:0]            i_riscv_ppreg_de_funct3,
  input  logic [6:0]            i_riscv_ppreg_de_func7,
  input  logic [XLEN-1:0]       i_riscv_ppreg_de_immzeroextend,
  output logic [XLEN-1:0]       o_riscv_ppreg_de_rs1data,
  output logic [XLEN-1:0]       o_riscv_ppreg_de_rs2data,
  output logic [REG_ADDR_W-1:0] o_riscv_ppreg_de_rs1addr,
  output logic [REG_ADDR_W-1:0] o_riscv_ppreg_de_rs2addr,
  output logic [REG_ADDR_W-1:0] o_riscv_ppreg_de_rdaddr,
  output logic [XLEN-1:0]       o_riscv_ppreg_de_simm,
  output logic [6:0]            o_riscv_ppreg_de_opcode,
  output logic [2:0]            o_riscv_ppreg_de_funct3,
  output logic [6:0]            o_riscv_ppreg_de_func7,
  output logic [XLEN-1:0]       o_riscv_ppreg_de_immzeroextend
);

  localparam int DE_W = 4*XLEN + 3*REG_ADDR_W + 17;  // 17 = func7 + funct3 + opcode

  // All fields zero except the opcode, which sits at the low end
  localparam logic [DE_W-1:0] BUBBLE = {{(DE_W-7){1'b0}}, riscv_pkg::NOP_INST[6:0]};

  logic [DE_W-1:0] de_d;
  logic [DE_W-1:0] de_q;

  assign de_d = i_riscv_ppreg_de_flush ? BUBBLE :
                {i_riscv_ppreg_de_rs1data, i_riscv_ppreg_de_rs2data,
                 i_riscv_ppreg_de_rs1addr, i_riscv_ppreg_de_rs2addr,
                 i_riscv_ppreg_de_rdaddr,  i_riscv_ppreg_de_simm,
                 i_riscv_ppreg_de_immzeroextend,
                 i_riscv_ppreg_de_func7,   i_riscv_ppreg_de_funct3,
                 i_riscv_ppreg_de_opcode};

  always_ff @(posedge i_riscv_ppreg_de_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      de_q <= BUBBLE;
    end else begin
      de_q <= de_d;
    end
  end

  assign {o_riscv_ppreg_de_rs1data, o_riscv_ppreg_de_rs2data,
          o_riscv_ppreg_de_rs1addr, o_riscv_ppreg_de_rs2addr,
          o_riscv_ppreg_de_rdaddr,  o_riscv_ppreg_de_simm,
          o_riscv_ppreg_de_immzeroextend,
          o_riscv_ppreg_de_func7,   o_riscv_ppreg_de_funct3,
          o_riscv_ppreg_de_opcode} = de_q;

  // A flushed slot must never write back in a later stage
  a_bubble_no_rd : assert property (
    @(posedge i_riscv_ppreg_de_clk) disable iff (!i_rst_n)
    i_riscv_ppreg_de_flush |=> (o_riscv_ppreg_de_rdaddr == '0)
  ) else $error("riscv_ppreg_de: bubble carries a nonzero rd");

endmodule

// ==== verilog/riscv_dstage_top.sv ====
`timescale 1ns/1ps

module riscv_dstage_top #(
  parameter int XLEN       = riscv_pkg::XLEN,
  parameter int REG_ADDR_W = riscv_pkg::REG_ADDR_W
) (
  input  logic                           i_riscv_dstage_top_clk,
  input  logic                           i_rst_n,
  input  logic                           i_stall_fd,
  input  logic                           i_flush_fd,
  input  logic                           i_flush_de,
  input  logic [31:0]                    i_inst,
  input  logic [riscv_pkg::IMMSRC_W-1:0] i_immsrc,
  input  logic                           i_regw,       // Write-back request
  input  logic [REG_ADDR_W-1:0]          i_rdaddr,
  input  logic [XLEN-1:0]                i_rddata,
  output logic [XLEN-1:0]                o_rs1data,
  output logic [XLEN-1:0]                o_rs2data,
  output logic [REG_ADDR_W-1:0]          o_rs1addr,
  output logic [REG_ADDR_W-1:0]          o_rs2addr,
  output logic [REG_ADDR_W-1:0]          o_rdaddr,
  output logic [XLEN-1:0]                o_simm,
  output logic [6:0]                     o_opcode,
  output logic [2:0]                     o_funct3,
  output logic [6:0]                     o_func7,
  output logic [XLEN-1:0]                o_immzeroextend
);

  riscv_pkg::riscv_inst_u         fd_inst;
  logic [riscv_pkg::IMMSRC_W-1:0] fd_immsrc;

  logic [XLEN-1:0]       d_rs1data;
  logic [XLEN-1:0]       d_rs2data;
  logic [REG_ADDR_W-1:0] d_rs1addr;
  logic [REG_ADDR_W-1:0] d_rs2addr;
  logic [REG_ADDR_W-1:0] d_rdaddr;
  logic [XLEN-1:0]       d_simm;
  logic [6:0]            d_opcode;
  logic [2:0]            d_funct3;
  logic [6:0]            d_func7;
  logic [XLEN-1:0]       d_immzeroextend;

  //////////////////////////////
  // Fetch / decode
  //////////////////////////////

  riscv_ppreg_fd u_riscv_ppreg_fd (
    .i_riscv_ppreg_fd_clk    (i_riscv_dstage_top_clk),
    .i_rst_n                 (i_rst_n),
    .i_riscv_ppreg_fd_stall  (i_stall_fd),
    .i_riscv_ppreg_fd_flush  (i_flush_fd),
    .i_riscv_ppreg_fd_inst   (i_inst),
    .i_riscv_ppreg_fd_immsrc (i_immsrc),
    .o_riscv_ppreg_fd_inst   (fd_inst),
    .o_riscv_ppreg_fd_immsrc (fd_immsrc)
  );

  riscv_dstage #(.XLEN(XLEN), .REG_ADDR_W(REG_ADDR_W)) u_riscv_dstage (
    .i_riscv_dstage_clk           (i_riscv_dstage_top_clk),
    .i_rst_n                      (i_rst_n),
    .i_riscv_dstage_immsrc        (fd_immsrc),
    .i_riscv_dstage_inst          (fd_inst),
    .i_riscv_dstage_regw          (i_regw),
    .i_riscv_dstage_rdaddr        (i_rdaddr),
    .i_riscv_dstage_rddata        (i_rddata),
    .o_riscv_dstage_rs1data       (d_rs1data),
    .o_riscv_dstage_rs2data       (d_rs2data),
    .o_riscv_dstage_rs1addr       (d_rs1addr),
    .o_riscv_dstage_rs2addr       (d_rs2addr),
    .o_riscv_dstage_rdaddr        (d_rdaddr),
    .o_riscv_dstage_simm          (d_simm),
    .o_riscv_dstage_opcode        (d_opcode),
    .o_riscv_dstage_funct3        (d_funct3),
    .o_riscv_dstage_func7         (d_func7),
    .o_riscv_dstage_immzeroextend (d_immzeroextend)
  );

  //////////////////////////////
  // Decode / execute
  //////////////////////////////

  riscv_ppreg_de #(.XLEN(XLEN), .REG_ADDR_W(REG_ADDR_W)) u_riscv_ppreg_de (
    .i_riscv_ppreg_de_clk           (i_riscv_dstage_top_clk),
    .i_rst_n                        (i_rst_n),
    .i_riscv_ppreg_de_flush         (i_flush_de),
    .i_riscv_ppreg_de_rs1data       (d_rs1data),
    .i_riscv_ppreg_de_rs2data       (d_rs2data),
    .i_riscv_ppreg_de_rs1addr       (d_rs1addr),
    .i_riscv_ppreg_de_rs2addr       (d_rs2addr),
    .i_riscv_ppreg_de_rdaddr        (d_rdaddr),
    .i_riscv_ppreg_de_simm          (d_simm),
    .i_riscv_ppreg_de_opcode        (d_opcode),
    .i_riscv_ppreg_de_funct3        (d_funct3),
    .i_riscv_ppreg_de_func7         (d_func7),
    .i_riscv_ppreg_de_immzeroextend (d_immzeroextend),
    .o_riscv_ppreg_de_rs1data       (o_rs1data),
    .o_riscv_ppreg_de_rs2data       (o_rs2data),
    .o_riscv_ppreg_de_rs1addr       (o_rs1addr),
    .o_riscv_ppreg_de_rs2addr       (o_rs2addr),
    .o_riscv_ppreg_de_rdaddr        (o_rdaddr),
    .o_riscv_ppreg_de_simm          (o_simm),
    .o_riscv_ppreg_de_opcode        (o_opcode),
    .o_riscv_ppreg_de_funct3        (o_funct3),
    .o_riscv_ppreg_de_func7         (o_func7),
    .o_riscv_ppreg_de_immzeroextend (o_immzeroextend)
  );

endmodule

// ==== sim/tb_riscv_dstage.sv ====
`timescale 1ns/1ps

module tb_riscv_dstage;

  localparam int XLEN = riscv_pkg::XLEN;
  localparam logic [31:0] NOP = riscv_pkg::NOP_INST;

  logic            clk;
  logic            i_rst_n;
  logic            i_stall_fd;
  logic            i_flush_fd;
  logic            i_flush_de;
  logic [31:0]     i_inst;
  logic [2:0]      i_immsrc;
  logic            i_regw;
  logic [4:0]      i_rdaddr;
  logic [XLEN-1:0] i_rddata;
  logic [XLEN-1:0] o_rs1data;
  logic [XLEN-1:0] o_rs2data;
  logic [4:0]      o_rs1addr;
  logic [4:0]      o_rs2addr;
  logic [4:0]      o_rdaddr;
  logic [XLEN-1:0] o_simm;
  logic [6:0]      o_opcode;
  logic [2:0]      o_funct3;
  logic [6:0]      o_func7;
  logic [XLEN-1:0] o_immzeroextend;

  logic [XLEN-1:0] rf_model [0:31];  // x0 entry stays zero
  logic [31:0]     lcg_state = 32'ha79f;
  logic [31:0]     q_inst [$];       // Instruction stream for run_stream
  logic [2:0]      q_sel [$];
  int              checks = 0;
  int              errors = 0;

  riscv_dstage_top #(
    .XLEN       (XLEN),
    .REG_ADDR_W (riscv_pkg::REG_ADDR_W)
  ) riscv_dstage_top_inst (
    .i_riscv_dstage_top_clk (clk),
    .i_rst_n                (i_rst_n),
    .i_stall_fd             (i_stall_fd),
    .i_flush_fd             (i_flush_fd),
    .i_flush_de             (i_flush_de),
    .i_inst                 (i_inst),
    .i_immsrc               (i_immsrc),
    .i_regw                 (i_regw),
    .i_rdaddr               (i_rdaddr),
    .i_rddata               (i_rddata),
    .o_rs1data              (o_rs1data),
    .o_rs2data              (o_rs2data),
    .o_rs1addr              (o_rs1addr),
    .o_rs2addr              (o_rs2addr),
    .o_rdaddr               (o_rdaddr),
    .o_simm                 (o_simm),
    .o_opcode               (o_opcode),
    .o_funct3               (o_funct3),
    .o_func7                (o_func7),
    .o_immzeroextend        (o_immzeroextend)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 10 ns period
  end

  //////////////////////////////
  // Stimulus helpers and model
  //////////////////////////////

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [31:0] rand_word();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = lcg_next();
    lo = lcg_next();
    return {hi[31:16], lo[31:16]};  // Upper bits are the better ones
  endfunction

  function automatic logic [2:0] rand_sel();
    logic [31:0] r;
    r = rand_word() % 5;  // Legal formats only
    return r[2:0];
  endfunction

  function automatic logic [4:0] rand_reg();
    logic [31:0] r;
    r = rand_word() % 31;
    return r[4:0] + 5'd1;  // x1 to x31
  endfunction

  // Immediate layouts of the base ISA with bit 31 as the sign
  function automatic logic [XLEN-1:0] imm_model(input logic [31:0] w, input logic [2:0] sel);
    case (sel)
      riscv_pkg::IMM_I: return {{52{w[31]}}, w[31:20]};
      riscv_pkg::IMM_S: return {{52{w[31]}}, w[31:25], w[11:7]};
      riscv_pkg::IMM_B: return {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
      riscv_pkg::IMM_U: return {{32{w[31]}}, w[31:12], 12'b0};
      riscv_pkg::IMM_J: return {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
      default:          return '0;
    endcase
  endfunction

  task automatic check_val(input string name, input string field,
                           input logic [63:0] exp, input logic [63:0] act);
    checks++;
    assert (act === exp) else begin
      $display("ERROR %s: %s expected %h, actual %h", name, field, exp, act);
      errors++;
    end
  endtask

  task automatic check_outputs(input string name, input logic [31:0] w, input logic [2:0] sel);
    logic [4:0] rs1;
    logic [4:0] rs2;
    rs1 = w[19:15];
    rs2 = w[24:20];
    check_val(name, "rs1data", rf_model[rs1], o_rs1data);
    check_val(name, "rs2data", rf_model[rs2], o_rs2data);
    check_val(name, "rs1addr", rs1, o_rs1addr);
    check_val(name, "rs2addr", rs2, o_rs2addr);
    check_val(name, "rdaddr", w[11:7], o_rdaddr);
    check_val(name, "simm", imm_model(w, sel), o_simm);
    check_val(name, "opcode", w[6:0], o_opcode);
    check_val(name, "funct3", w[14:12], o_funct3);
    check_val(name, "func7", w[31:25], o_func7);
    check_val(name, "immzeroextend", {59'b0, rs1}, o_immzeroextend);
  endtask

  task automatic drive_inst(input logic [31:0] w, input logic [2:0] sel);
    i_inst   <= w;
    i_immsrc <= sel;
  endtask

  task automatic write_reg(input logic [4:0] addr, input logic [XLEN-1:0] data);
    @(posedge clk);
    i_regw   <= 1'b1;
    i_rdaddr <= addr;
    i_rddata <= data;
    if (addr != 5'd0) rf_model[addr] = data;  // x0 ignores writes
    @(posedge clk);
    i_regw <= 1'b0;
  endtask

  // Issue the queued instructions back to back, each checked two edges later
  task automatic run_stream(input string name);
    int n;
    n = q_inst.size();
    for (int i = 0; i < n + 2; i++) begin
      @(posedge clk);
      if (i < n) drive_inst(q_inst[i], q_sel[i]);
      else drive_inst(NOP, riscv_pkg::IMM_I);
      @(negedge clk);
      if (i >= 2) check_outputs(name, q_inst[i-2], q_sel[i-2]);
    end
    q_inst.delete();
    q_sel.delete();
  endtask

  //////////////////////////////
  // Directed tests
  //////////////////////////////

  // Reset value of decode/execute first, then the decode of the fetch/decode reset value
  task automatic test_reset();
    repeat (2) begin
      @(negedge clk);
      check_outputs("reset", NOP, riscv_pkg::IMM_I);  // All zero but the opcode
    end
  endtask

  task automatic test_fields();
    for (int i = 0; i < 8; i++) begin
      q_inst.push_back(rand_word());
      q_sel.push_back(rand_sel());
    end
    run_stream("fields");
  endtask

  task automatic test_regfile();
    logic [4:0]  addr [0:7];
    logic [4:0]  a;
    logic [31:0] w;
    for (int i = 0; i < 8; i++) begin
      addr[i] = rand_reg();
      write_reg(addr[i], {rand_word(), rand_word()});
    end
    for (int i = 0; i < 8; i++) begin
      q_inst.push_back({7'h00, addr[(i+1)%8], addr[i], 3'b000, rand_reg(), 7'h33});
      q_sel.push_back(riscv_pkg::IMM_I);
    end
    run_stream("regfile");
    write_reg(5'd0, {rand_word(), rand_word()});
    q_inst.push_back({7'h00, 5'd0, 5'd0, 3'b000, 5'd1, 7'h33});
    q_sel.push_back(riscv_pkg::IMM_I);
    run_stream("x0_write");
    a = rand_reg();
    w = {7'h00, a, a, 3'b000, 5'd2, 7'h33};
    @(posedge clk);
    drive_inst(w, riscv_pkg::IMM_I);
    @(posedge clk);                     // Instruction now in decode
    drive_inst(NOP, riscv_pkg::IMM_I);
    i_regw   <= 1'b1;
    i_rdaddr <= a;
    i_rddata <= ~rf_model[a];           // Differs from the old value
    rf_model[a] = ~rf_model[a];
    @(posedge clk);
    i_regw <= 1'b0;
    @(negedge clk);
    check_outputs("write_first", w, riscv_pkg::IMM_I);
  endtask

  task automatic test_imm();
    logic [31:0] w;
    for (int s = 0; s < 5; s++) begin
      for (int k = 0; k < 4; k++) begin
        q_inst.push_back(rand_word());
        q_sel.push_back(s[2:0]);
      end
    end
    run_stream("imm");
    for (int s = 5; s < 8; s++) begin
      w = rand_word();
      q_inst.push_back({w[31:7], 7'h13});  // Reserved code only with NOP opcode
      q_sel.push_back(s[2:0]);
    end
    run_stream("imm_reserved");
  endtask

  task automatic test_stall();
    logic [31:0] held;
    logic [31:0] next;
    logic [2:0]  held_sel;
    logic [2:0]  next_sel;
    held = rand_word();
    held_sel = rand_sel();
    next = rand_word();
    next_sel = rand_sel();
    @(posedge clk);
    drive_inst(held, held_sel);
    @(posedge clk);
    drive_inst(rand_word(), rand_sel());
    i_stall_fd <= 1'b1;
    repeat (3) begin
      @(posedge clk);
      drive_inst(rand_word(), rand_sel());  // Ignored while stalled
      @(negedge clk);
      check_outputs("stall", held, held_sel);
    end
    @(posedge clk);
    drive_inst(next, next_sel);
    i_stall_fd <= 1'b0;
    @(negedge clk);
    check_outputs("stall", held, held_sel);
    @(posedge clk);
    drive_inst(NOP, riscv_pkg::IMM_I);
    @(negedge clk);
    check_outputs("stall", held, held_sel);
    @(posedge clk);
    @(negedge clk);
    check_outputs("stall_release", next, next_sel);
  endtask

  task automatic test_flush();
    logic [31:0] a;
    logic [31:0] c;
    logic [2:0]  sa;
    logic [2:0]  sc;
    a = rand_word();
    sa = rand_sel();
    c = rand_word();
    sc = rand_sel();
    @(posedge clk);
    drive_inst(a, sa);
    @(posedge clk);
    drive_inst(rand_word(), rand_sel());  // Squashed in fetch/decode
    i_flush_fd <= 1'b1;
    @(posedge clk);
    drive_inst(c, sc);
    i_flush_fd <= 1'b0;
    @(negedge clk);
    check_outputs("flush_fd", a, sa);
    @(posedge clk);
    drive_inst(NOP, riscv_pkg::IMM_I);
    @(negedge clk);
    check_outputs("flush_fd", NOP, riscv_pkg::IMM_I);
    @(posedge clk);
    @(negedge clk);
    check_outputs("flush_fd", c, sc);
    @(posedge clk);
    drive_inst(rand_word(), rand_sel());  // Squashed in decode/execute
    @(posedge clk);
    drive_inst(a, sa);
    i_flush_de <= 1'b1;
    @(posedge clk);
    drive_inst(NOP, riscv_pkg::IMM_I);
    i_flush_de <= 1'b0;
    @(negedge clk);
    check_outputs("flush_de", NOP, riscv_pkg::IMM_I);
    @(posedge clk);
    @(negedge clk);
    check_outputs("flush_de", a, sa);
  endtask

  initial begin
    i_rst_n    = 1'b0;
    i_stall_fd = 1'b0;
    i_flush_fd = 1'b0;
    i_flush_de = 1'b0;
    i_inst     = NOP;
    i_immsrc   = riscv_pkg::IMM_I;
    i_regw     = 1'b0;
    i_rdaddr   = '0;
    i_rddata   = '0;
    for (int i = 0; i < 32; i++) begin
      rf_model[i] = '0;
    end
    repeat (3) @(posedge clk);
    i_rst_n <= 1'b1;
    test_reset();
    test_fields();
    test_regfile();
    test_imm();
    test_stall();
    test_flush();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== riscv_dstage.f ====
verilog/riscv_pkg.sv
verilog/riscv_rf_if.sv
verilog/riscv_rf.sv
verilog/riscv_extend.sv
verilog/riscv_dstage.sv
verilog/riscv_ppreg_fd.sv
verilog/riscv_ppreg_de.sv
verilog/riscv_dstage_top.sv
sim/tb_riscv_dstage.sv
